// File: design/mipsIsaPkg.sv
/*
 * Instruction-set definitions shared by the core and its testbench.
 * Field types, opcode and funct encodings, ALU operation codes, reset PC.
 */
package mipsIsaPkg;

	typedef logic [31:0] word;   // data or address
	typedef logic [4:0]  regAddr; // register number
	typedef logic [5:0]  opcode;  // bits 31:26
	typedef logic [5:0]  funct;   // bits 5:0, r-type only

	// alu operation, 3-bit alucontrol encoding
	typedef enum logic [2:0] {
		aluAnd = 3'b000,
		aluOr  = 3'b001,
		aluAdd = 3'b010,
		aluSub = 3'b110,
		aluSlt = 3'b111 // signed compare
	} aluOp;

	// primary opcodes
	localparam opcode opRType = 6'b000000; // add sub and or slt
	localparam opcode opLw    = 6'b100011;
	localparam opcode opSw    = 6'b101011;
	localparam opcode opBeq   = 6'b000100;
	localparam opcode opAddi  = 6'b001000;
	localparam opcode opJ     = 6'b000010;

	// r-type funct codes
	localparam funct fnAdd = 6'b100000;
	localparam funct fnSub = 6'b100010;
	localparam funct fnAnd = 6'b100100;
	localparam funct fnOr  = 6'b100101;
	localparam funct fnSlt = 6'b101010;

	// $zero, hardwired
	localparam regAddr zeroReg = 5'd0;

	// first fetch address
	localparam word resetPc = 32'h0000_0000;

endpackage : mipsIsaPkg

// File: design/mipsPipePkg.sv
/*
 * Pipeline-level types for the five-stage core.
 * Control word, forwarding select and the four pipeline register layouts.
 */
package mipsPipePkg;

	import mipsIsaPkg::*;

	// decoded control, all zero is a nop
	typedef struct packed {
		logic regWrite; // write rf in wb
		logic memToReg; // result from dmem
		logic memWrite; // sw
		logic regDst;   // rd when set, else rt
		logic aluSrc;   // immediate as operand b
		logic branch;   // beq
		logic jump;     // j
		aluOp aluCtl;
	} ctrlWord;

	// execute operand source
	typedef enum logic [1:0] {
		fwdRegFile = 2'b00, // value read in decode
		fwdWb      = 2'b01, // writeback result
		fwdMem     = 2'b10  // alu result in mem stage
	} fwdSel;

	// fetch to decode
	typedef struct packed {
		word instr;
		word pcPlus4;
	} ifId;

	// decode to execute
	typedef struct packed {
		ctrlWord ctrl;
		word     a;
		word     b;
		word     signImm;
		regAddr  rs;
		regAddr  rt;
		regAddr  rd;
	} idEx;

	// execute to memory, only what mem and wb still need
	typedef struct packed {
		logic   regWrite;
		logic   memToReg;
		logic   memWrite;
		word    aluOut;
		word    writeData; // store data after forwarding
		regAddr writeReg;
	} exMem;

	// memory to writeback
	typedef struct packed {
		logic   regWrite;
		logic   memToReg;
		word    readData;
		word    aluOut;
		regAddr writeReg;
	} memWb;

endpackage : mipsPipePkg

// File: design/controller.sv
/*
 * Main and ALU decoder for the decode stage.
 * Maps opcode and funct to a control word; unknown encodings decode as a nop.
 */
`timescale 1ns/1ps

module controller
	import mipsIsaPkg::*, mipsPipePkg::*;
(
	input  opcode   op,
	input  funct    fn,
	output ctrlWord ctrl
);

	always_comb begin
		ctrl = '0; // default nop
		case (op)
			opRType: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst   = 1'b1; // dest in rd
				// alu decoder
				case (fn)
					fnAdd: ctrl.aluCtl = aluAdd;
					fnSub: ctrl.aluCtl = aluSub;
					fnAnd: ctrl.aluCtl = aluAnd;
					fnOr:  ctrl.aluCtl = aluOr;
					fnSlt: ctrl.aluCtl = aluSlt;
					default: begin
						ctrl = '0; // all-zero word lands here too
					end
				endcase
			end
			opLw: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc   = 1'b1; // base + offset
				ctrl.aluCtl   = aluAdd;
			end
			opSw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.aluCtl   = aluAdd;
			end
			opBeq: begin
				ctrl.branch = 1'b1; // compared in decode
				ctrl.aluCtl = aluSub; // alu result unused
			end
			opAddi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.aluCtl   = aluAdd;
			end
			opJ: begin
				ctrl.jump = 1'b1;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule : controller

// File: design/regFile.sv
/*
 * 32 x 32 register file, two combinational read ports and one write port.
 * Reads see a write in the same cycle; register 0 reads as zero.
 */
`timescale 1ns/1ps

module regFile
	import mipsIsaPkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  regAddr ra1,
	input  regAddr ra2,
	input  regAddr wa,
	input  logic   we,
	input  word    wd,
	output word    rd1,
	output word    rd2
);

	word regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != zeroReg) begin
			regs[wa] <= wd;
		end
	end

	// bypass the write port so wb and decode can share a cycle
	assign rd1 = (ra1 == zeroReg) ? '0 : (we && ra1 == wa) ? wd : regs[ra1];
	assign rd2 = (ra2 == zeroReg) ? '0 : (we && ra2 == wa) ? wd : regs[ra2];

endmodule : regFile

// File: design/hazardUnit.sv
/*
 * Hazard detection and forwarding control.
 * Picks forward sources for execute and the branch compare, and raises stall and flush.
 */
`timescale 1ns/1ps

module hazardUnit
	import mipsIsaPkg::*, mipsPipePkg::*;
(
	input  regAddr  rsD,
	input  regAddr  rtD,
	input  regAddr  rsE,
	input  regAddr  rtE,
	input  regAddr  writeRegE,
	input  regAddr  writeRegM,
	input  regAddr  writeRegW,
	input  ctrlWord ctrlE,
	input  ctrlWord ctrlM,
	input  logic    regWriteW,
	input  logic    branchD,
	output logic    stallF,
	output logic    stallD,
	output logic    flushE,
	output logic    forwardAD,
	output logic    forwardBD,
	output fwdSel   forwardA,
	output fwdSel   forwardB
);

	logic lwStall;
	logic branchStall;

	// mem stage before wb, never from $zero
	function automatic fwdSel pickFwd(regAddr src, regAddr dstM, logic weM,
			regAddr dstW, logic weW);
		if (src != zeroReg && src == dstM && weM) return fwdMem;
		if (src != zeroReg && src == dstW && weW) return fwdWb;
		return fwdRegFile;
	endfunction

	assign forwardA = pickFwd(rsE, writeRegM, ctrlM.regWrite, writeRegW, regWriteW);
	assign forwardB = pickFwd(rtE, writeRegM, ctrlM.regWrite, writeRegW, regWriteW);

	// branch compare only takes the mem alu result, wb goes through the rf bypass
	assign forwardAD = (rsD != zeroReg) && (rsD == writeRegM) && ctrlM.regWrite;
	assign forwardBD = (rtD != zeroReg) && (rtD == writeRegM) && ctrlM.regWrite;

	// load in execute feeding decode
	assign lwStall = ctrlE.memToReg && (writeRegE == rsD || writeRegE == rtD);

	// beq operands not ready yet
	assign branchStall = branchD &&
		((ctrlE.regWrite && (writeRegE == rsD || writeRegE == rtD)) ||
		 (ctrlM.memToReg && (writeRegM == rsD || writeRegM == rtD)));

	assign stallF = lwStall | branchStall; // hold pc
	assign stallD = lwStall | branchStall; // hold ifId
	assign flushE = lwStall | branchStall; // bubble into idEx

endmodule : hazardUnit

// File: design/decodeStage.sv
/*
 * Decode stage datapath with the register file.
 * Reads operands, extends the immediate, resolves beq equality and branch/jump targets.
 */
`timescale 1ns/1ps

module decodeStage
	import mipsIsaPkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  word    inst,
	input  word    pcPlus4,
	input  logic   regWriteW,
	input  regAddr writeRegW,
	input  word    resultW,
	input  logic   forwardAD,
	input  logic   forwardBD,
	input  word    aluOutM,
	output word    a,
	output word    b,
	output word    signImm,
	output word    branchTarget,
	output word    jumpTarget,
	output logic   equal
);

	regAddr rs;
	regAddr rt;
	word    cmpA; // compare operands after forwarding
	word    cmpB;

	assign rs = inst[25:21];
	assign rt = inst[20:16];

	// write port driven from wb
	regFile i_regFile (
		.clk  (clk),
		.reset(reset),
		.ra1  (rs),
		.ra2  (rt),
		.wa   (writeRegW),
		.we   (regWriteW),
		.wd   (resultW),
		.rd1  (a),
		.rd2  (b)
	);

	assign signImm = {{16{inst[15]}}, inst[15:0]};

	// word offset relative to pc+4
	assign branchTarget = pcPlus4 + {signImm[29:0], 2'b00};
	assign jumpTarget   = {pcPlus4[31:28], inst[25:0], 2'b00}; // same 256MB region

	assign cmpA  = forwardAD ? aluOutM : a;
	assign cmpB  = forwardBD ? aluOutM : b;
	assign equal = (cmpA == cmpB);

endmodule : decodeStage

// File: design/executeStage.sv
/*
 * Execute stage datapath.
 * Forwarding muxes, immediate select, ALU and destination register choice.
 */
`timescale 1ns/1ps

module executeStage
	import mipsIsaPkg::*, mipsPipePkg::*;
(
	input  idEx    stage,
	input  fwdSel  forwardA,
	input  fwdSel  forwardB,
	input  word    aluOutM,
	input  word    resultW,
	output word    aluOut,
	output word    writeData,
	output regAddr writeReg
);

	word srcA;
	word srcB;

	function automatic word fwdMux(fwdSel sel, word rfVal, word memVal, word wbVal);
		case (sel)
			fwdMem:  return memVal;
			fwdWb:   return wbVal;
			default: return rfVal;
		endcase
	endfunction

	assign srcA      = fwdMux(forwardA, stage.a, aluOutM, resultW);
	assign writeData = fwdMux(forwardB, stage.b, aluOutM, resultW); // sw data too
	assign srcB      = stage.ctrl.aluSrc ? stage.signImm : writeData;

	always_comb begin
		case (stage.ctrl.aluCtl)
			aluAnd:  aluOut = srcA & srcB;
			aluOr:   aluOut = srcA | srcB;
			aluSub:  aluOut = srcA - srcB; // wraps
			aluSlt:  aluOut = {31'b0, $signed(srcA) < $signed(srcB)};
			default: aluOut = srcA + srcB; // add, wraps
		endcase
	end

	assign writeReg = stage.ctrl.regDst ? stage.rd : stage.rt;

endmodule : executeStage

// File: design/mips.sv
/*
 * Five-stage pipelined MIPS core with separate instruction and data ports.
 * Holds the pc and pipeline registers; memories sit outside and answer combinationally.
 */
`timescale 1ns/1ps

module mips
	import mipsIsaPkg::*, mipsPipePkg::*;
(
	input  logic clk,
	input  logic reset,
	output word  pcImem,
	input  word  imemInstn,
	output logic dmemWe,
	output word  dmemAddr,
	output word  dmemWd,
	input  word  dmemRd
);

	// fetch
	word pcF;
	word pcPlus4F;
	word pcNext;

	// decode
	ifId     ifIdR;
	ctrlWord ctrlD;
	regAddr  rsD, rtD, rdD;
	word     aD, bD, signImmD;
	word     branchTargetD, jumpTargetD;
	logic    equalD;
	logic    pcSrcD;   // beq taken
	logic    flushD;   // squash the slot behind a redirect
	idEx     idExD;

	// execute
	idEx    idExR;
	word    aluOutE, writeDataE;
	regAddr writeRegE;

	// memory
	exMem    exMemR;
	ctrlWord ctrlM; // widened for the hazard unit

	// writeback
	memWb memWbR;
	word  resultW;

	// hazard
	logic  stallF, stallD, flushE;
	logic  forwardAD, forwardBD;
	fwdSel forwardA, forwardB;

	// pc and fetch
	assign pcPlus4F = pcF + 32'd4;
	assign pcSrcD   = ctrlD.branch & equalD;

	always_comb begin
		if (ctrlD.jump) pcNext = jumpTargetD;
		else if (pcSrcD) pcNext = branchTargetD;
		else pcNext = pcPlus4F;
	end

	always_ff @(posedge clk) begin
		if (reset) pcF <= resetPc;
		else if (!stallF) pcF <= pcNext;
	end

	assign pcImem = pcF;

	// ifId, zero instr decodes as nop
	assign flushD = (pcSrcD | ctrlD.jump) & ~stallD;

	always_ff @(posedge clk) begin
		if (reset || flushD) begin
			ifIdR <= '0;
		end else if (!stallD) begin
			ifIdR.instr   <= imemInstn;
			ifIdR.pcPlus4 <= pcPlus4F;
		end
	end

	// decode
	assign rsD = ifIdR.instr[25:21];
	assign rtD = ifIdR.instr[20:16];
	assign rdD = ifIdR.instr[15:11];

	controller i_controller (
		.op  (ifIdR.instr[31:26]),
		.fn  (ifIdR.instr[5:0]),
		.ctrl(ctrlD)
	);

	decodeStage i_decodeStage (
		.clk         (clk),
		.reset       (reset),
		.inst        (ifIdR.instr),
		.pcPlus4     (ifIdR.pcPlus4),
		.regWriteW   (memWbR.regWrite),
		.writeRegW   (memWbR.writeReg),
		.resultW     (resultW),
		.forwardAD   (forwardAD),
		.forwardBD   (forwardBD),
		.aluOutM     (exMemR.aluOut),
		.a           (aD),
		.b           (bD),
		.signImm     (signImmD),
		.branchTarget(branchTargetD),
		.jumpTarget  (jumpTargetD),
		.equal       (equalD)
	);

	assign idExD = '{ctrl: ctrlD, a: aD, b: bD, signImm: signImmD,
		rs: rsD, rt: rtD, rd: rdD};

	// idEx, bubble on hazard
	always_ff @(posedge clk) begin
		if (reset || flushE) idExR <= '0;
		else idExR <= idExD;
	end

	// execute
	executeStage i_executeStage (
		.stage    (idExR),
		.forwardA (forwardA),
		.forwardB (forwardB),
		.aluOutM  (exMemR.aluOut),
		.resultW  (resultW),
		.aluOut   (aluOutE),
		.writeData(writeDataE),
		.writeReg (writeRegE)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			exMemR <= '0;
		end else begin
			exMemR.regWrite  <= idExR.ctrl.regWrite;
			exMemR.memToReg  <= idExR.ctrl.memToReg;
			exMemR.memWrite  <= idExR.ctrl.memWrite;
			exMemR.aluOut    <= aluOutE;
			exMemR.writeData <= writeDataE;
			exMemR.writeReg  <= writeRegE;
		end
	end

	// memory stage
	assign dmemAddr = exMemR.aluOut;
	assign dmemWd   = exMemR.writeData;
	assign dmemWe   = exMemR.memWrite;

	always_comb begin
		ctrlM          = '0;
		ctrlM.regWrite = exMemR.regWrite;
		ctrlM.memToReg = exMemR.memToReg;
		ctrlM.memWrite = exMemR.memWrite;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			memWbR <= '0;
		end else begin
			memWbR.regWrite <= exMemR.regWrite;
			memWbR.memToReg <= exMemR.memToReg;
			memWbR.readData <= dmemRd;
			memWbR.aluOut   <= exMemR.aluOut;
			memWbR.writeReg <= exMemR.writeReg;
		end
	end

	// writeback
	assign resultW = memWbR.memToReg ? memWbR.readData : memWbR.aluOut;

	hazardUnit i_hazardUnit (
		.rsD      (rsD),
		.rtD      (rtD),
		.rsE      (idExR.rs),
		.rtE      (idExR.rt),
		.writeRegE(writeRegE),
		.writeRegM(exMemR.writeReg),
		.writeRegW(memWbR.writeReg),
		.ctrlE    (idExR.ctrl),
		.ctrlM    (ctrlM),
		.regWriteW(memWbR.regWrite),
		.branchD  (ctrlD.branch),
		.stallF   (stallF),
		.stallD   (stallD),
		.flushE   (flushE),
		.forwardAD(forwardAD),
		.forwardBD(forwardBD),
		.forwardA (forwardA),
		.forwardB (forwardB)
	);

endmodule : mips

// File: dv/mips_properties.sv
/*
 * Concurrent checks on the core's fetch and store ports and its stall signal.
 * Bound into every mips instance; failures are counted for the testbench.
 */
`timescale 1ns/1ps

module mipsProperties
	import mipsIsaPkg::*;
(
	input logic clk,
	input logic reset,
	input word  pcImem,
	input logic dmemWe,
	input word  dmemAddr,
	input logic stallF,
	input word  branchTarget, // decode stage targets
	input word  jumpTarget
);

	int unsigned failCount = 0;

	// reset puts fetch at resetPc with no store in flight
	resetState: assert property (@(posedge clk) reset |=> pcImem == resetPc && !dmemWe)
		else begin failCount++; $error("pc not at reset address or store strobe high"); end

	// first fetched word needs three edges to reach memory
	noEarlyStore: assert property (@(posedge clk) $fell(reset) |-> !dmemWe [*3])
		else begin failCount++; $error("store strobe high too soon after reset"); end

	// a stall holds the pc for one cycle only
	stallHold: assert property (@(posedge clk) disable iff (reset)
		stallF |=> pcImem == $past(pcImem) && !stallF)
		else begin failCount++; $error("pc stall wrong length or pc moved"); end

	pcAligned: assert property (@(posedge clk) disable iff (reset) pcImem[1:0] == 2'b00)
		else begin failCount++; $error("fetch address not word aligned"); end

	pcStep: assert property (@(posedge clk) disable iff (reset)
		1'b1 |=> pcImem == $past(pcImem) + 32'd4 || pcImem == $past(pcImem) ||
			pcImem == $past(branchTarget) || pcImem == $past(jumpTarget))
		else begin failCount++; $error("pc moved to an address it cannot reach"); end

	storeAligned: assert property (@(posedge clk) disable iff (reset)
		dmemWe |-> dmemAddr[1:0] == 2'b00)
		else begin failCount++; $error("store address not word aligned"); end

endmodule : mipsProperties

bind mips mipsProperties i_props (
	.clk         (clk),
	.reset       (reset),
	.pcImem      (pcImem),
	.dmemWe      (dmemWe),
	.dmemAddr    (dmemAddr),
	.stallF      (stallF),
	.branchTarget(branchTargetD),
	.jumpTarget  (jumpTargetD)
);

// File: dv/mipsTb.sv
/*
 * Testbench for the pipelined MIPS core: clock, reset, both memories and a test program.
 * Stores are checked in program order against values worked out from the ISA rules.
 */
`timescale 1ns/1ps

module mipsTb
	import mipsIsaPkg::*;
();

	localparam int clkPeriod   = 8;
	localparam int resetCycles = 10;
	localparam int driveDelay  = 1;   // ns after the rising edge
	localparam int drainCycles = 20;  // watch for stray stores at the end
	localparam int maxCycles   = 400; // ~10x the 30-word program, reset and drain included
	localparam logic [31:0] seed = 32'h430a2a4c;

	typedef struct packed {
		word addr;
		word data;
	} storeRec;

	logic clk;
	logic reset;
	word  pcImem;
	word  imemInstn;
	logic dmemWe;
	word  dmemAddr;
	word  dmemWd;
	word  dmemRd;

	word imem [256]; // word indexed
	word dmem [256];

	storeRec     expQ[$]; // stores still to come, program order
	string       expName[$];
	int unsigned cycleCount;
	int unsigned putIdx;

	mips i_dut (
		.clk      (clk),
		.reset    (reset),
		.pcImem   (pcImem),
		.imemInstn(imemInstn),
		.dmemWe   (dmemWe),
		.dmemAddr (dmemAddr),
		.dmemWd   (dmemWd),
		.dmemRd   (dmemRd)
	);

	// both memories answer in the same cycle
	assign imemInstn = imem[pcImem[9:2]];
	assign dmemRd    = dmem[dmemAddr[9:2]];

	always @(posedge clk) begin
		if (dmemWe) dmem[dmemAddr[9:2]] <= dmemWd;
	end

	function automatic logic [31:0] nextRandom(logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// initial data memory contents, built from the full byte address
	function automatic word fillWord(word addr);
		return addr ^ 32'hc3a5_5a3c;
	endfunction

	function automatic word signExt(logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic word rType(funct f, regAddr rd, regAddr rs, regAddr rt);
		return {opRType, rs, rt, rd, 5'd0, f};
	endfunction

	function automatic word iType(opcode op, regAddr rt, regAddr rs, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word jType(word target);
		return {opJ, target[27:2]};
	endfunction

	task automatic abortRun();
		$display("FAIL: see errors above");
		$fatal(1, "run stopped at cycle %0d", cycleCount);
	endtask

	task automatic put(word instr);
		imem[putIdx] = instr;
		putIdx++;
	endtask

	// sw rt, addr($zero) that has to show up on the data port
	task automatic storeWord(string name, regAddr rt, word addr, word value);
		put(iType(opSw, rt, 5'd0, addr[15:0]));
		expQ.push_back(storeRec'{addr, value});
		expName.push_back(name);
	endtask

	task automatic buildProgram();
		word         rnd;
		logic [15:0] imm0;
		logic [15:0] imm1;
		logic [15:0] immN;
		logic [15:0] immB;
		word         r [16]; // register values the program should produce
		rnd  = seed;
		rnd  = nextRandom(rnd);
		imm0 = rnd[15:0] & 16'h7fff; // positive, slt pair needs it
		rnd  = nextRandom(rnd);
		imm1 = rnd[15:0];
		rnd  = nextRandom(rnd);
		immN = rnd[15:0] | 16'h8000; // negative
		rnd  = nextRandom(rnd);
		immB = rnd[15:0] & 16'h7fff; // never equals the negative r7
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0; // zero word is a nop
			dmem[i] = fillWord(word'(i) << 2);
		end
		putIdx = 0;
		// first fetch is a store, earliest strobe after reset
		storeWord("storeZero", 5'd0, 32'h7c, 32'd0);
		// dependent alu chain, mem and wb forwarding
		r[1] = signExt(imm0);
		put(iType(opAddi, 5'd1, 5'd0, imm0));
		r[2] = r[1] + signExt(imm1);
		put(iType(opAddi, 5'd2, 5'd1, imm1));
		r[3] = r[2] + r[1];
		put(rType(fnAdd, 5'd3, 5'd2, 5'd1));
		r[4] = r[3] - r[2];
		put(rType(fnSub, 5'd4, 5'd3, 5'd2));
		r[5] = r[4] & r[3];
		put(rType(fnAnd, 5'd5, 5'd4, 5'd3));
		r[6] = r[5] | r[4];
		put(rType(fnOr, 5'd6, 5'd5, 5'd4));
		storeWord("fwdOr", 5'd6, 32'h90, r[6]); // store data forwarded from mem
		r[7] = signExt(immN);
		put(iType(opAddi, 5'd7, 5'd0, immN));
		r[8] = ($signed(r[7]) < $signed(r[1])) ? 32'd1 : 32'd0;
		put(rType(fnSlt, 5'd8, 5'd7, 5'd1));
		r[9] = ($signed(r[1]) < $signed(r[7])) ? 32'd1 : 32'd0;
		put(rType(fnSlt, 5'd9, 5'd1, 5'd7));
		storeWord("fwdAddi", 5'd2, 32'h80, r[2]);
		storeWord("fwdAdd", 5'd3, 32'h84, r[3]);
		storeWord("fwdSub", 5'd4, 32'h88, r[4]);
		storeWord("fwdAnd", 5'd5, 32'h8c, r[5]);
		storeWord("sltNegLess", 5'd8, 32'h94, r[8]);
		storeWord("sltPosLess", 5'd9, 32'h98, r[9]);
		// load-use, one bubble
		r[10] = fillWord(32'h40);
		put(iType(opLw, 5'd10, 5'd0, 16'h0040));
		r[11] = r[10] + r[1];
		put(rType(fnAdd, 5'd11, 5'd10, 5'd1));
		storeWord("loadUse", 5'd11, 32'h9c, r[11]);
		// taken beq on a register still in execute
		r[13] = signExt(immB);
		put(iType(opAddi, 5'd13, 5'd0, immB));
		r[12] = signExt(immB);
		put(iType(opAddi, 5'd12, 5'd0, immB));
		put(iType(opBeq, 5'd13, 5'd12, 16'd1));
		put(iType(opSw, 5'd1, 5'd0, 16'h00a0)); // squashed slot
		storeWord("beqTaken", 5'd12, 32'ha4, r[12]);
		put(iType(opBeq, 5'd7, 5'd12, 16'd1)); // falls through
		storeWord("beqNotTaken", 5'd7, 32'ha8, r[7]);
		put(jType(word'(putIdx + 2) << 2));
		put(iType(opSw, 5'd1, 5'd0, 16'h00ac)); // squashed slot
		storeWord("jump", 5'd13, 32'hb0, r[13]);
		put(jType(word'(putIdx) << 2)); // spin here
	endtask

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// store port, sampled mid-cycle
	always @(negedge clk) begin
		storeRec exp;
		string   name;
		assert (i_dut.i_props.failCount == 0) else begin
			$display("a bound assertion on the core failed at cycle %0d", cycleCount);
			abortRun();
		end
		if (!reset && dmemWe) begin
			assert (expQ.size() != 0) else begin
				$display("extra store to %h with data %h after the last expected one",
					dmemAddr, dmemWd);
				abortRun();
			end
			exp  = expQ.pop_front();
			name = expName.pop_front();
			assert (dmemAddr == exp.addr) else begin
				$display("MISMATCH %s address: expected %h actual %h", name, exp.addr, dmemAddr);
				abortRun();
			end
			assert (dmemWd == exp.data) else begin
				$display("MISMATCH %s data: expected %h actual %h", name, exp.data, dmemWd);
				abortRun();
			end
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		assert (cycleCount < maxCycles) else begin
			$display("timeout after %0d cycles with %0d stores still missing",
				cycleCount, expQ.size());
			abortRun();
		end
	end

	initial begin
		reset      = 1'b1;
		cycleCount = 0;
		buildProgram();
		repeat (resetCycles) @(posedge clk);
		#driveDelay reset = 1'b0;
		while (expQ.size() != 0) @(posedge clk);
		repeat (drainCycles) @(posedge clk);
		if (i_dut.i_props.failCount != 0) begin
			$display("a bound assertion on the core failed");
			abortRun();
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule : mipsTb

// File: src.f
design/mipsIsaPkg.sv
design/mipsPipePkg.sv
design/controller.sv
design/regFile.sv
design/hazardUnit.sv
design/decodeStage.sv
design/executeStage.sv
design/mips.sv
dv/mips_properties.sv
dv/mipsTb.sv
